//--- hw/videoPkg.sv
// pixel and colour types, pattern codes, timing-load states, bar colours, pipeline latency
package videoPkg;

    // --------------------------------------
    // pixel types
    // --------------------------------------
    typedef logic [7:0]  colorT;    // one channel
    typedef logic [23:0] pixelT;    // red in top byte, then green, then blue

    // --------------------------------------
    // pattern select codes
    // --------------------------------------
    typedef logic [1:0] patSelT;

    localparam patSelT PAT_SOLID    = 2'd0;
    localparam patSelT PAT_BARS     = 2'd1;
    localparam patSelT PAT_GRADIENT = 2'd2;
    localparam patSelT PAT_CHECKER  = 2'd3;

    // timing register load sequence
    typedef enum logic [1:0] {
        LOAD_WAIT_FIRST,    // no valid timing yet, generator held
        LOAD_RUN,           // live set in use
        LOAD_PENDING        // shadow newer than live, wait for frame end
    } loadStateT;

    // reset and fixed colours
    localparam pixelT PIXEL_BLACK = 24'h000000;
    localparam pixelT PIXEL_WHITE = 24'hffffff;

    // classic eight bars, left to right
    localparam pixelT BAR_COLORS [8] = '{
        24'hffffff,     // white
        24'hffff00,     // yellow
        24'h00ffff,     // cyan
        24'h00ff00,     // green
        24'hff00ff,     // magenta
        24'hff0000,     // red
        24'h0000ff,     // blue
        24'h000000      // black
    };

    localparam int PIPE_LATENCY = 2;    // pattern pipeline depth in clocks

endpackage

//--- hw/videoTimingRegs.sv
// shadow and live display timing registers with frame-end transfer and generator hold
`timescale 1ns/1ps

module videoTimingRegs
    import videoPkg::*;
#(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11
)(
    input  logic                      iVideoClk,
    input  logic                      rst,
    input  logic                      iTimingWe,     // one-cycle write strobe
    input  logic [pHdisplayWidth-1:0] iHdisplay,
    input  logic [pVdisplayWidth-1:0] iVdisplay,
    input  logic [pHdisplayWidth:0]   iHSyncStart,
    input  logic [pHdisplayWidth:0]   iHSyncEnd,
    input  logic [pHdisplayWidth:0]   iHSyncMax,
    input  logic [pVdisplayWidth:0]   iVSyncStart,
    input  logic [pVdisplayWidth:0]   iVSyncEnd,
    input  logic [pVdisplayWidth:0]   iVSyncMax,
    input  logic                      fe,            // frame end from sync gen
    output logic [pHdisplayWidth-1:0] hdisplay,
    output logic [pVdisplayWidth-1:0] vdisplay,
    output logic [pHdisplayWidth:0]   hSyncStart,
    output logic [pHdisplayWidth:0]   hSyncEnd,
    output logic [pHdisplayWidth:0]   hSyncMax,
    output logic [pVdisplayWidth:0]   vSyncStart,
    output logic [pVdisplayWidth:0]   vSyncEnd,
    output logic [pVdisplayWidth:0]   vSyncMax,
    output logic                      genHold        // counter reset for sync gen
);

    // --------------------------------------
    // shadow set
    // --------------------------------------
    logic [pHdisplayWidth-1:0] shadowHdisplay;
    logic [pVdisplayWidth-1:0] shadowVdisplay;
    logic [pHdisplayWidth:0]   shadowHSyncStart;
    logic [pHdisplayWidth:0]   shadowHSyncEnd;
    logic [pHdisplayWidth:0]   shadowHSyncMax;
    logic [pVdisplayWidth:0]   shadowVSyncStart;
    logic [pVdisplayWidth:0]   shadowVSyncEnd;
    logic [pVdisplayWidth:0]   shadowVSyncMax;

    loadStateT loadState;
    logic      copyLive;    // shadow to live on the next edge

    always_ff @(posedge iVideoClk)
    begin
        if (iTimingWe)      // a later write just overwrites
        begin
            shadowHdisplay   <= iHdisplay;
            shadowVdisplay   <= iVdisplay;
            shadowHSyncStart <= iHSyncStart;
            shadowHSyncEnd   <= iHSyncEnd;
            shadowHSyncMax   <= iHSyncMax;
            shadowVSyncStart <= iVSyncStart;
            shadowVSyncEnd   <= iVSyncEnd;
            shadowVSyncMax   <= iVSyncMax;
        end
    end

    // --------------------------------------
    // load FSM
    // --------------------------------------
    always_ff @(posedge iVideoClk)
    begin
        if (rst)
        begin
            loadState <= LOAD_WAIT_FIRST;
            copyLive  <= 1'b0;
        end
        else
        begin
            copyLive <= 1'b0;
            case (loadState)
                LOAD_WAIT_FIRST:
                begin
                    if (iTimingWe)      // first config goes live at once
                    begin
                        loadState <= LOAD_RUN;
                        copyLive  <= 1'b1;
                    end
                end
                LOAD_RUN:
                begin
                    if (iTimingWe)
                        loadState <= LOAD_PENDING;
                end
                LOAD_PENDING:
                begin
                    if (fe)             // frame boundary, no torn frame
                    begin
                        loadState <= LOAD_RUN;
                        copyLive  <= 1'b1;
                    end
                end
                default:
                    loadState <= LOAD_WAIT_FIRST;
            endcase
        end
    end

    // live set, valid once genHold drops
    always_ff @(posedge iVideoClk)
    begin
        if (copyLive)
        begin
            hdisplay   <= shadowHdisplay;
            vdisplay   <= shadowVdisplay;
            hSyncStart <= shadowHSyncStart;
            hSyncEnd   <= shadowHSyncEnd;
            hSyncMax   <= shadowHSyncMax;
            vSyncStart <= shadowVSyncStart;
            vSyncEnd   <= shadowVSyncEnd;
            vSyncMax   <= shadowVSyncMax;
        end
    end

    // release one cycle after the first copy, never set again
    always_ff @(posedge iVideoClk)
    begin
        if (rst)
            genHold <= 1'b1;
        else if (loadState != LOAD_WAIT_FIRST && !copyLive)
            genHold <= 1'b0;
    end

endmodule

//--- hw/videoSyncGen.sv
// horizontal and vertical counters, sync, data enable and frame-end generation
`timescale 1ns/1ps

module videoSyncGen #(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11
)(
    input  logic                      iVideoClk,
    input  logic                      rst,
    input  logic                      genHold,       // held until timing is live
    input  logic [pHdisplayWidth-1:0] hdisplay,
    input  logic [pVdisplayWidth-1:0] vdisplay,
    input  logic [pHdisplayWidth:0]   hSyncStart,
    input  logic [pHdisplayWidth:0]   hSyncEnd,
    input  logic [pHdisplayWidth:0]   hSyncMax,
    input  logic [pVdisplayWidth:0]   vSyncStart,
    input  logic [pVdisplayWidth:0]   vSyncEnd,
    input  logic [pVdisplayWidth:0]   vSyncMax,
    output logic                      hSync,         // active low
    output logic                      vSync,         // active low
    output logic                      vde,           // video data enable
    output logic                      fe             // frame end pulse
);

    logic cntRst;
    assign cntRst = rst | genHold;

    // --------------------------------------
    // horizontal counter
    // --------------------------------------
    logic [pHdisplayWidth:0] hpos;
    logic                    hWrap;
    logic                    hSyncArea;

    // wrap at or past max so a shrinking max cannot run away
    assign hWrap     = (hpos >= hSyncMax);
    assign hSyncArea = (hSyncStart <= hpos) && (hpos <= hSyncEnd);

    always_ff @(posedge iVideoClk)
    begin
        if (cntRst)
            hpos <= '0;
        else if (hWrap)
            hpos <= '0;
        else
            hpos <= hpos + 1'b1;
    end

    // --------------------------------------
    // vertical counter
    // --------------------------------------
    logic [pVdisplayWidth:0] vpos;
    logic                    vWrap;
    logic                    vSyncArea;

    assign vWrap     = (vpos >= vSyncMax);
    assign vSyncArea = (vSyncStart <= vpos) && (vpos <= vSyncEnd);

    always_ff @(posedge iVideoClk)
    begin
        if (cntRst)
            vpos <= '0;
        else if (hWrap)     // one step per line
        begin
            if (vWrap)
                vpos <= '0;
            else
                vpos <= vpos + 1'b1;
        end
    end

    // --------------------------------------
    // enable and frame end decode
    // --------------------------------------
    logic vdeNext;
    logic feNext;

    assign vdeNext = (hpos < {1'b0, hdisplay}) && (vpos < {1'b0, vdisplay});
    assign feNext  = (hpos == {1'b0, hdisplay}) && (vpos == {1'b0, vdisplay});

    // all outputs one cycle behind the counters
    always_ff @(posedge iVideoClk)
    begin
        if (cntRst)
        begin
            hSync <= 1'b1;
            vSync <= 1'b1;
            vde   <= 1'b0;
            fe    <= 1'b0;
        end
        else
        begin
            hSync <= ~hSyncArea;
            vSync <= ~vSyncArea;
            vde   <= vdeNext;
            fe    <= feNext;
        end
    end

endmodule

//--- hw/videoPatternGen.sv
// two-stage test pattern pipeline with solid, colour bar, gradient and checker pixels
`timescale 1ns/1ps

module videoPatternGen
    import videoPkg::*;
#(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11,
    parameter int pBarShift      = 4     // log2 of bar width in pixels
)(
    input  logic   iVideoClk,
    input  logic   rst,
    input  logic   vde,
    input  logic   fe,
    input  patSelT iPattern,             // static level
    input  pixelT  iSolidColor,          // static level
    output pixelT  pixel                 // valid two clocks after vde
);

    // --------------------------------------
    // stage one coordinates
    // --------------------------------------
    logic [pHdisplayWidth-1:0] xCnt;     // x of the current enabled cycle
    logic [pVdisplayWidth-1:0] yCnt;
    logic                      vdePrev;

    always_ff @(posedge iVideoClk)
    begin
        if (rst)
        begin
            xCnt    <= '0;
            yCnt    <= '0;
            vdePrev <= 1'b0;
        end
        else
        begin
            vdePrev <= vde;
            if (vde)
                xCnt <= xCnt + 1'b1;
            else
                xCnt <= '0;     // cleared across blanking
            if (fe)
                yCnt <= '0;
            else if (vdePrev && !vde)   // end of an active line
                yCnt <= yCnt + 1'b1;
        end
    end

    logic [pHdisplayWidth-1:0] xS1;
    logic [pVdisplayWidth-1:0] yS1;
    patSelT                    patS1;
    pixelT                     solidS1;

    // sampled per pixel so a select change lands cleanly
    always_ff @(posedge iVideoClk)
    begin
        xS1     <= xCnt;
        yS1     <= yCnt;
        patS1   <= iPattern;
        solidS1 <= iSolidColor;
    end

    // --------------------------------------
    // stage two pixel select
    // --------------------------------------
    colorT      gradRed;
    colorT      gradGreen;
    colorT      gradBlue;
    logic [2:0] barIdx;
    pixelT      pixelNext;

    assign gradRed   = xS1[7:0];
    assign gradGreen = yS1[7:0];
    assign gradBlue  = gradRed ^ gradGreen;
    assign barIdx    = xS1[pBarShift+2:pBarShift];

    always_comb
    begin
        case (patS1)
            PAT_SOLID:
                pixelNext = solidS1;
            PAT_BARS:
                pixelNext = BAR_COLORS[barIdx];
            PAT_GRADIENT:
                pixelNext = {gradRed, gradGreen, gradBlue};
            PAT_CHECKER:                // 8x8 squares
                pixelNext = (xS1[3] ^ yS1[3]) ? PIXEL_WHITE : PIXEL_BLACK;
            default:
                pixelNext = PIXEL_BLACK;
        endcase
    end

    always_ff @(posedge iVideoClk)
    begin
        pixel <= pixelNext;             // blanked downstream
    end

endmodule

//--- hw/videoOutAlign.sv
// strobe delay line matched to the pattern pipeline and pixel blanking
`timescale 1ns/1ps

module videoOutAlign
    import videoPkg::*;
(
    input  logic  iVideoClk,
    input  logic  rst,
    input  logic  hSync,
    input  logic  vSync,
    input  logic  vde,
    input  logic  fe,
    input  pixelT pixel,
    output logic  oHSync,
    output logic  oVSync,
    output logic  oVde,
    output logic  oFe,
    output pixelT oPixel
);

    // {hSync, vSync, vde, fe} with syncs idle high
    localparam logic [3:0] IDLE_STROBES = 4'b1100;

    // --------------------------------------
    // strobe shift line
    // --------------------------------------
    logic [3:0] strobeLine [PIPE_LATENCY];

    always_ff @(posedge iVideoClk)
    begin
        if (rst)
        begin
            for (int i = 0; i < PIPE_LATENCY; i++)
                strobeLine[i] <= IDLE_STROBES;
        end
        else
        begin
            strobeLine[0] <= {hSync, vSync, vde, fe};
            for (int i = 1; i < PIPE_LATENCY; i++)
                strobeLine[i] <= strobeLine[i-1];
        end
    end

    assign {oHSync, oVSync, oVde, oFe} = strobeLine[PIPE_LATENCY-1];

    // black outside the active area
    assign oPixel = oVde ? pixel : PIXEL_BLACK;

endmodule

//--- hw/videoTop.sv
// video timing and test pattern source top level, four blocks wired in a chain
`timescale 1ns/1ps

module videoTop
    import videoPkg::*;
#(
    parameter int pHdisplayWidth = 11,
    parameter int pVdisplayWidth = 11,
    parameter int pBarShift      = 4
)(
    input  logic                      iVideoClk,
    input  logic                      rst,
    input  logic                      iTimingWe,
    input  logic [pHdisplayWidth-1:0] iHdisplay,
    input  logic [pVdisplayWidth-1:0] iVdisplay,
    input  logic [pHdisplayWidth:0]   iHSyncStart,
    input  logic [pHdisplayWidth:0]   iHSyncEnd,
    input  logic [pHdisplayWidth:0]   iHSyncMax,
    input  logic [pVdisplayWidth:0]   iVSyncStart,
    input  logic [pVdisplayWidth:0]   iVSyncEnd,
    input  logic [pVdisplayWidth:0]   iVSyncMax,
    input  patSelT                    iPattern,
    input  pixelT                     iSolidColor,
    output logic                      oHSync,
    output logic                      oVSync,
    output logic                      oVde,
    output logic                      oFe,
    output pixelT                     oPixel
);

    // --------------------------------------
    // live timing and generator strobes
    // --------------------------------------
    logic [pHdisplayWidth-1:0] hdisplay;
    logic [pVdisplayWidth-1:0] vdisplay;
    logic [pHdisplayWidth:0]   hSyncStart, hSyncEnd, hSyncMax;
    logic [pVdisplayWidth:0]   vSyncStart, vSyncEnd, vSyncMax;
    logic                      genHold;
    logic                      hSync, vSync, vde, fe;
    pixelT                     pixel;   // pattern output, not yet blanked

    videoTimingRegs #(
        .pHdisplayWidth (pHdisplayWidth),
        .pVdisplayWidth (pVdisplayWidth)
    ) timingRegs_i (
        .iVideoClk (iVideoClk),     .rst (rst),                 .iTimingWe (iTimingWe),
        .iHdisplay (iHdisplay),     .iVdisplay (iVdisplay),
        .iHSyncStart (iHSyncStart), .iHSyncEnd (iHSyncEnd),     .iHSyncMax (iHSyncMax),
        .iVSyncStart (iVSyncStart), .iVSyncEnd (iVSyncEnd),     .iVSyncMax (iVSyncMax),
        .fe (fe),                   .hdisplay (hdisplay),       .vdisplay (vdisplay),
        .hSyncStart (hSyncStart),   .hSyncEnd (hSyncEnd),       .hSyncMax (hSyncMax),
        .vSyncStart (vSyncStart),   .vSyncEnd (vSyncEnd),       .vSyncMax (vSyncMax),
        .genHold (genHold)
    );

    videoSyncGen #(
        .pHdisplayWidth (pHdisplayWidth),
        .pVdisplayWidth (pVdisplayWidth)
    ) syncGen_i (
        .iVideoClk (iVideoClk),     .rst (rst),                 .genHold (genHold),
        .hdisplay (hdisplay),       .vdisplay (vdisplay),
        .hSyncStart (hSyncStart),   .hSyncEnd (hSyncEnd),       .hSyncMax (hSyncMax),
        .vSyncStart (vSyncStart),   .vSyncEnd (vSyncEnd),       .vSyncMax (vSyncMax),
        .hSync (hSync),             .vSync (vSync),             .vde (vde),
        .fe (fe)
    );

    videoPatternGen #(
        .pHdisplayWidth (pHdisplayWidth),
        .pVdisplayWidth (pVdisplayWidth),
        .pBarShift      (pBarShift)
    ) patternGen_i (
        .iVideoClk (iVideoClk),     .rst (rst),                 .vde (vde),
        .fe (fe),                   .iPattern (iPattern),       .iSolidColor (iSolidColor),
        .pixel (pixel)
    );

    // strobes delayed to meet the pixel
    videoOutAlign outAlign_i (
        .iVideoClk (iVideoClk),     .rst (rst),
        .hSync (hSync),             .vSync (vSync),             .vde (vde),
        .fe (fe),                   .pixel (pixel),
        .oHSync (oHSync),           .oVSync (oVSync),           .oVde (oVde),
        .oFe (oFe),                 .oPixel (oPixel)
    );

endmodule

//--- testbench/videoClkGen.sv
// testbench video clock and synchronous active-high reset source
`timescale 1ns/1ps

module videoClkGen #(
    parameter int pHalfPeriod  = 20,    // 40 ns clock
    parameter int pResetCycles = 4
)(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(pHalfPeriod) clk = ~clk;
    end

    // released on the edge after the last reset cycle
    initial
    begin
        rst = 1'b1;
        repeat (pResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- testbench/videoTb.sv
// video source testbench with directed tests, pixel reference model, compare tasks, LFSR and watchdog
`timescale 1ns/1ps

module videoTb
    import videoPkg::*;
();

    // small test timing
    localparam int H_DISP     = 16;
    localparam int H_SS       = 18;
    localparam int H_SE       = 20;
    localparam int H_MAX      = 23;
    localparam int H_MAX_SKIP = 25;     // overwritten while still pending
    localparam int H_MAX_NEW  = 27;
    localparam int V_DISP     = 6;
    localparam int V_SS       = 7;
    localparam int V_SE       = 8;
    localparam int V_MAX      = 9;
    localparam int BAR_SHIFT  = 2;      // 4 pixel bars on a 16 pixel line

    localparam int FRAME_CYCLES    = (H_MAX + 1) * (V_MAX + 1);
    localparam int LONGEST_FRAME   = (H_MAX_NEW + 1) * (V_MAX + 1);
    localparam int WATCHDOG_CYCLES = 12 * LONGEST_FRAME + 200;

    logic        videoClk;
    logic        rst;
    logic        timingWe;
    logic [10:0] hdisplay;
    logic [10:0] vdisplay;
    logic [11:0] hSyncStart;
    logic [11:0] hSyncEnd;
    logic [11:0] hSyncMax;
    logic [11:0] vSyncStart;
    logic [11:0] vSyncEnd;
    logic [11:0] vSyncMax;
    patSelT      pattern;
    pixelT       solidColor;
    logic        hSync;
    logic        vSync;
    logic        vde;
    logic        fe;
    pixelT       pixel;

    int          errorCount = 0;
    int          checksRun  = 0;
    logic [31:0] lfsrState  = 32'h546b;
    int          firstCycles;
    bit          firstFound;

    videoClkGen #(.pHalfPeriod (20), .pResetCycles (4)) clkGen_i (.clk (videoClk), .rst (rst));

    videoTop #(
        .pHdisplayWidth (11),
        .pVdisplayWidth (11),
        .pBarShift      (BAR_SHIFT)
    ) dut_i (
        .iVideoClk (videoClk),       .rst (rst),              .iTimingWe (timingWe),
        .iHdisplay (hdisplay),       .iVdisplay (vdisplay),
        .iHSyncStart (hSyncStart),   .iHSyncEnd (hSyncEnd),   .iHSyncMax (hSyncMax),
        .iVSyncStart (vSyncStart),   .iVSyncEnd (vSyncEnd),   .iVSyncMax (vSyncMax),
        .iPattern (pattern),         .iSolidColor (solidColor),
        .oHSync (hSync),             .oVSync (vSync),         .oVde (vde),
        .oFe (fe),                   .oPixel (pixel)
    );

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic checkBit(input string what, input logic got, input logic exp);
        checksRun++;
        if (got !== exp)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic checkCount(input string what, input int got, input int exp);
        checksRun++;
        if (got != exp)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkPixel(input string what, input pixelT got, input pixelT exp);
        checksRun++;
        if (got !== exp)
        begin
            errorCount++;
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ----------------------------------------
    // reference model of the pixel rule
    // ----------------------------------------
    // white yellow cyan green magenta red blue black, every channel full or off
    function automatic pixelT barColor(input logic [2:0] idx);
        colorT r;
        colorT g;
        colorT b;
        r = {8{~idx[1]}};
        g = {8{~idx[2]}};
        b = {8{~idx[0]}};
        return {r, g, b};
    endfunction

    function automatic pixelT expectedPixel(input patSelT pat, input int x, input int y,
                                            input pixelT solid);
        logic [10:0] xv;
        logic [10:0] yv;
        xv = x[10:0];
        yv = y[10:0];
        case (pat)
            PAT_SOLID:
                return solid;
            PAT_BARS:
                return barColor(xv[BAR_SHIFT+2:BAR_SHIFT]);
            PAT_GRADIENT:
                return {xv[7:0], yv[7:0], xv[7:0] ^ yv[7:0]};
            default:                    // checker, 8 pixel squares
                return (xv[3] != yv[3]) ? 24'hffffff : 24'h000000;
        endcase
    endfunction

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h80200003;
        return n;
    endfunction

    task automatic drawBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            bits      = {bits[30:0], lfsrState[0]};    // one step per bit
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // ----------------------------------------
    // drive and wait helpers
    // ----------------------------------------
    task automatic nextDriveSlot();
        @(posedge videoClk);
        #2;                             // inputs change 2 ns after the edge
    endtask

    task automatic writeTiming(input int hMax);
        nextDriveSlot();
        timingWe   = 1'b1;
        hdisplay   = 11'(H_DISP);
        vdisplay   = 11'(V_DISP);
        hSyncStart = 12'(H_SS);
        hSyncEnd   = 12'(H_SE);
        hSyncMax   = 12'(hMax);
        vSyncStart = 12'(V_SS);
        vSyncEnd   = 12'(V_SE);
        vSyncMax   = 12'(V_MAX);
        nextDriveSlot();
        timingWe   = 1'b0;              // single-cycle strobe
    endtask

    // outputs sampled on the falling edge, away from the driving edge
    task automatic waitFrameEnd(input int limit, output int cycles, output bit found);
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit)
        begin
            @(negedge videoClk);
            cycles++;
            found = fe;
        end
        if (!found)
        begin
            errorCount++;
            $display("%0t ns: no frame-end pulse within %0d cycles", $time, limit);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic idleBeforeConfig();
        repeat (50)
        begin
            @(negedge videoClk);
            checkBit("idle hSync", hSync, 1'b1);
            checkBit("idle vSync", vSync, 1'b1);
            checkBit("idle vde", vde, 1'b0);
            checkBit("idle fe", fe, 1'b0);
            checkPixel("idle pixel", pixel, 24'h000000);
        end
    endtask

    // one frame, starting just after a frame-end sample
    task automatic syncShape();
        int   cycles;
        int   sinceFall;
        int   hLowRun;
        int   hFalls;
        int   vdeRun;
        int   vdeLines;
        int   vdeTotal;
        int   vLowTotal;
        logic prevH;
        logic prevVde;
        bit   found;
        cycles    = 0;
        sinceFall = -1;                 // no fall seen yet
        hLowRun   = 0;
        hFalls    = 0;
        vdeRun    = 0;
        vdeLines  = 0;
        vdeTotal  = 0;
        vLowTotal = 0;
        prevH     = 1'b1;
        prevVde   = 1'b0;
        found     = 1'b0;
        while (!found && cycles < FRAME_CYCLES + 1)
        begin
            @(negedge videoClk);
            cycles++;
            if (sinceFall >= 0)
                sinceFall++;
            if (!hSync && prevH)        // hsync falling
            begin
                hFalls++;
                if (sinceFall >= 0)
                    checkCount("hSync period", sinceFall, H_MAX + 1);
                sinceFall = 0;
            end
            if (!hSync)
                hLowRun++;
            else if (!prevH)
            begin
                checkCount("hSync low width", hLowRun, H_SE - H_SS + 1);
                hLowRun = 0;
            end
            if (vde)
            begin
                vdeRun++;
                vdeTotal++;
                if (!prevVde)
                    vdeLines++;
            end
            else if (prevVde)           // end of an active line
            begin
                checkCount("vde line length", vdeRun, H_DISP);
                vdeRun = 0;
            end
            if (!vSync)
                vLowTotal++;
            prevH   = hSync;
            prevVde = vde;
            found   = fe;
        end
        if (!found)
        begin
            errorCount++;
            $display("%0t ns: frame end missing after one frame of sync shape", $time);
        end
        checkCount("hSync pulses per frame", hFalls, V_MAX + 1);
        checkCount("active lines per frame", vdeLines, V_DISP);
        checkCount("active cycles per frame", vdeTotal, H_DISP * V_DISP);
        checkCount("vSync low cycles", vLowTotal, (V_SE - V_SS + 1) * (H_MAX + 1));
    endtask

    task automatic frameEndPeriod();
        int cycles;
        bit found;
        repeat (2)
        begin
            waitFrameEnd(FRAME_CYCLES + 20, cycles, found);
            if (found)
            begin
                checkCount("frame period", cycles, FRAME_CYCLES);   // catches extra pulses
                checkBit("vde on frame end", vde, 1'b0);
            end
        end
    endtask

    task automatic patternFrames();
        int          x;
        int          y;
        int          cycles;
        int          pixels;
        logic        prevVde;
        bit          found;
        logic [31:0] bits;
        pixelT       solid;
        drawBits(24, bits);
        solid = bits[23:0];
        for (int p = 0; p < 4; p++)
        begin
            nextDriveSlot();            // still in blanking after frame end
            pattern    = patSelT'(p);
            solidColor = solid;
            x       = 0;
            y       = 0;
            cycles  = 0;
            pixels  = 0;
            prevVde = 1'b0;
            found   = 1'b0;
            while (!found && cycles < FRAME_CYCLES + 1)
            begin
                @(negedge videoClk);
                cycles++;
                if (vde)
                begin
                    checkPixel($sformatf("pattern %0d pixel (%0d,%0d)", p, x, y), pixel,
                               expectedPixel(patSelT'(p), x, y, solid));
                    x++;
                    pixels++;
                end
                else
                begin
                    checkPixel($sformatf("pattern %0d blank pixel", p), pixel, 24'h000000);
                    if (prevVde)        // next line
                    begin
                        x = 0;
                        y++;
                    end
                end
                prevVde = vde;
                found   = fe;
            end
            if (!found)
            begin
                errorCount++;
                $display("%0t ns: frame end missing in pattern %0d frame", $time, p);
            end
            checkCount("active pixels per frame", pixels, H_DISP * V_DISP);
        end
    endtask

    // line period follows the value live when the line started
    task automatic doubleBufferUpdate();
        int   cycles;
        int   sinceFall;
        int   afterFe;
        bit   feSeen;
        bit   startedAfterFe;
        logic prevH;
        repeat (100) @(posedge videoClk);   // mid-frame
        writeTiming(H_MAX_SKIP);
        writeTiming(H_MAX_NEW);
        cycles         = 0;
        sinceFall      = -1;
        afterFe        = 0;
        feSeen         = 1'b0;
        startedAfterFe = 1'b0;
        @(negedge videoClk);
        prevH = hSync;
        while (afterFe < 4 && cycles < 2 * LONGEST_FRAME)
        begin
            @(negedge videoClk);
            cycles++;
            if (sinceFall >= 0)
                sinceFall++;
            if (!hSync && prevH)
            begin
                if (sinceFall >= 0)
                begin
                    if (startedAfterFe)
                    begin
                        checkCount("line period after update", sinceFall, H_MAX_NEW + 1);
                        afterFe++;
                    end
                    else
                        checkCount("line period before update", sinceFall, H_MAX + 1);
                end
                sinceFall      = 0;
                startedAfterFe = feSeen;
            end
            if (fe)
                feSeen = 1'b1;
            prevH = hSync;
        end
        if (!feSeen)
        begin
            errorCount++;
            $display("%0t ns: no frame-end pulse after the timing writes", $time);
        end
        else if (afterFe < 4)
        begin
            errorCount++;
            $display("%0t ns: too few lines seen after the timing update", $time);
        end
    endtask

    // ----------------------------------------
    // run and watchdog
    // ----------------------------------------
    initial
    begin
        timingWe   = 1'b0;
        hdisplay   = '0;
        vdisplay   = '0;
        hSyncStart = '0;
        hSyncEnd   = '0;
        hSyncMax   = '0;
        vSyncStart = '0;
        vSyncEnd   = '0;
        vSyncMax   = '0;
        pattern    = PAT_SOLID;
        solidColor = '0;
        wait (rst == 1'b0);
        idleBeforeConfig();
        writeTiming(H_MAX);
        waitFrameEnd(FRAME_CYCLES + 20, firstCycles, firstFound);
        syncShape();
        frameEndPeriod();
        patternFrames();
        doubleBufferUpdate();
        $display("checks: %0d, errors: %0d", checksRun, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge videoClk);
        $display("%0t ns: timeout, tests not done after %0d cycles", $time, WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog.f
hw/videoPkg.sv
hw/videoTimingRegs.sv
hw/videoSyncGen.sv
hw/videoPatternGen.sv
hw/videoOutAlign.sv
hw/videoTop.sv
testbench/videoClkGen.sv
testbench/videoTb.sv
